// File: src/thinpad_pkg.sv
package thinpad_pkg;

    // one request on the instruction or data bus
    typedef struct packed {
        logic        read;     // level, held until stall is low
        logic        write;    // level, held until stall is low
        logic [31:0] address;  // byte address
        logic [31:0] wdata;
        logic [3:0]  be;       // byte mask, bit 0 is wdata[7:0]
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdata;   // valid in the cycle stall drops
        logic        stall;
    } bus_resp_t;

    // pins toward the asynchronous base_ram
    typedef struct packed {
        logic [19:0] addr;    // word address
        logic [31:0] wdata;
        logic        drive;   // data output enable
        logic [3:0]  be_n;
        logic        ce_n;
        logic        oe_n;
        logic        we_n;
    } sram_pins_t;

    typedef enum logic [1:0] {
        idle        = 2'd0,
        data_access = 2'd1,
        inst_access = 2'd2,
        done        = 2'd3
    } sram_state_t;

    // boot rom, 16 words at the mips reset vector
    localparam logic [31:0] bootrom_base  = 32'h1fc0_0000;
    localparam int          bootrom_words = 16;
    localparam logic [31:0] bootrom_mask  = 32'hffff_ffc0;

    // base_ram window, 4 MiB
    localparam logic [31:0] ram_base = 32'h8000_0000;
    localparam logic [31:0] ram_mask = 32'hffc0_0000;

    // cycle timer, two registers
    localparam logic [31:0] timer_base        = 32'hbfd0_0000;
    localparam logic [31:0] timer_mask        = 32'hffff_fff8;
    localparam logic [31:0] timer_count_off   = 32'h0000_0000;
    localparam logic [31:0] timer_compare_off = 32'h0000_0004;

endpackage

// File: src/instruction_bus.sv
`timescale 1ns/1ps

module instruction_bus (
    input  thinpad_pkg::bus_req_t  cpu_req,
    output thinpad_pkg::bus_resp_t cpu_resp,
    output thinpad_pkg::bus_req_t  rom_req,
    input  thinpad_pkg::bus_resp_t rom_resp,
    output thinpad_pkg::bus_req_t  ram_req,
    input  thinpad_pkg::bus_resp_t ram_resp
);
    import thinpad_pkg::*;

    logic sel_rom;
    logic sel_ram;

    assign sel_rom = (cpu_req.address & bootrom_mask) == bootrom_base;
    assign sel_ram = (cpu_req.address & ram_mask) == ram_base;

    // fetch only, so writes never reach a slave
    always_comb begin
        rom_req       = cpu_req;
        rom_req.read  = cpu_req.read & sel_rom;
        rom_req.write = 1'b0;

        ram_req       = cpu_req;
        ram_req.read  = cpu_req.read & sel_ram;
        ram_req.write = 1'b0;
    end

    // response back from whichever slave the address hits
    always_comb begin
        if (sel_rom) begin
            cpu_resp = rom_resp;
        end else if (sel_ram) begin
            cpu_resp = ram_resp;
        end else begin
            cpu_resp = '0; // unmapped, zero and no stall
        end
    end

endmodule

// File: src/data_bus.sv
`timescale 1ns/1ps

module data_bus (
    input  thinpad_pkg::bus_req_t  cpu_req,
    output thinpad_pkg::bus_resp_t cpu_resp,
    output thinpad_pkg::bus_req_t  ram_req,
    input  thinpad_pkg::bus_resp_t ram_resp,
    output thinpad_pkg::bus_req_t  timer_req,
    input  thinpad_pkg::bus_resp_t timer_resp
);
    import thinpad_pkg::*;

    logic sel_ram;
    logic sel_timer;

    assign sel_ram   = (cpu_req.address & ram_mask) == ram_base;
    assign sel_timer = (cpu_req.address & timer_mask) == timer_base;

    // address, data and mask go to both slaves, strobes only to the hit
    always_comb begin
        ram_req         = cpu_req;
        ram_req.read    = cpu_req.read & sel_ram;
        ram_req.write   = cpu_req.write & sel_ram;

        timer_req       = cpu_req;
        timer_req.read  = cpu_req.read & sel_timer;
        timer_req.write = cpu_req.write & sel_timer;
    end

    always_comb begin
        if (sel_ram) begin
            cpu_resp = ram_resp;
        end else if (sel_timer) begin
            cpu_resp = timer_resp;
        end else begin
            // nothing mapped here, write dropped and read gives zero
            cpu_resp = '0;
        end
    end

endmodule

// File: src/bootrom.sv
`timescale 1ns/1ps

module bootrom (
    input  logic                   clk,
    input  logic                   rst_n,
    input  thinpad_pkg::bus_req_t  req,
    output thinpad_pkg::bus_resp_t resp
);
    import thinpad_pkg::*;

    localparam int idx_w = $clog2(bootrom_words);

    logic [31:0] rom [bootrom_words];
    logic [31:0] rdata_q;
    logic        served;   // word is in rdata_q this cycle

    initial begin
        $readmemh("src/bootrom.mem", rom);
    end

    // one cycle of stall per fetch, then the registered word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            served <= 1'b0;
        end else begin
            served <= req.read & ~served;
        end
    end

    always_ff @(posedge clk) begin
        if (req.read && !served) begin
            rdata_q <= rom[req.address[idx_w+1:2]];
        end
    end

    always_comb begin
        resp.rdata = rdata_q;
        resp.stall = req.read & ~served;
    end

endmodule

// File: src/timer.sv
`timescale 1ns/1ps

module timer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  thinpad_pkg::bus_req_t  req,
    output thinpad_pkg::bus_resp_t resp,
    output logic                   irq
);
    import thinpad_pkg::*;

    logic [31:0] count;
    logic [31:0] compare;
    logic        sel_compare;
    logic        irq_q;

    assign sel_compare = (req.address & ~timer_mask) == timer_compare_off;

    // free running and wraps around
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            count <= count + 32'd1;
        end
    end

    // compare write per byte lane
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            compare <= '1; // never fires until written
        end else if (req.write && sel_compare) begin
            for (int i = 0; i < 4; i++) begin
                if (req.be[i]) begin
                    compare[8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= count >= compare;
        end
    end

    assign irq = irq_q;

    always_comb begin
        resp.stall = 1'b0;   // registers answer at once
        resp.rdata = (req.address[2:0] != timer_count_off[2:0]) ? compare : count;
    end

endmodule

// File: src/sram_controller.sv
`timescale 1ns/1ps

module sram_controller #(
    parameter int unsigned sram_wait = 2   // cycles per access, 1 to 7
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  thinpad_pkg::bus_req_t   inst_req,
    output thinpad_pkg::bus_resp_t  inst_resp,
    input  thinpad_pkg::bus_req_t   data_req,
    output thinpad_pkg::bus_resp_t  data_resp,
    output thinpad_pkg::sram_pins_t sram,
    input  logic [31:0]             sram_rdata
);
    import thinpad_pkg::*;

    sram_state_t state;
    logic [2:0]  wait_cnt;
    logic        gnt_data;     // data port owns the current access

    logic        data_pending;
    logic        inst_pending;
    logic        start_data;
    logic        start_inst;
    logic        in_access;
    logic        last_cycle;
    bus_req_t    sel_req;

    // control pins, registered so the strobes come straight from flops
    logic        ce_n_q;
    logic        oe_n_q;
    logic        we_n_q;
    logic        drive_q;

    // payload
    logic [19:0] addr_q;
    logic [31:0] wdata_q;
    logic [3:0]  be_n_q;
    logic [31:0] rdata_q;

    assign data_pending = data_req.read | data_req.write;
    assign inst_pending = inst_req.read | inst_req.write;
    assign in_access    = (state == data_access) || (state == inst_access);
    assign last_cycle   = in_access && (wait_cnt == 3'd0);

    // grant, data first; in done the finishing port cannot be regranted
    always_comb begin
        start_data = 1'b0;
        start_inst = 1'b0;
        case (state)
            idle: begin
                start_data = data_pending;
                start_inst = ~data_pending & inst_pending;
            end
            done: begin
                if (gnt_data) begin
                    start_inst = inst_pending;
                end else begin
                    start_data = data_pending;
                end
            end
            default: ;
        endcase
    end

    assign sel_req = start_data ? data_req : inst_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= idle;
            wait_cnt <= '0;
            gnt_data <= 1'b0;
            ce_n_q   <= 1'b1;
            oe_n_q   <= 1'b1;
            we_n_q   <= 1'b1;
            drive_q  <= 1'b0;
        end else if (start_data || start_inst) begin
            state    <= start_data ? data_access : inst_access;
            wait_cnt <= 3'(sram_wait - 1);
            gnt_data <= start_data;
            ce_n_q   <= 1'b0;
            oe_n_q   <= sel_req.write;   // output enable only for reads
            we_n_q   <= ~sel_req.write;
            drive_q  <= sel_req.write;
        end else if (last_cycle) begin
            state  <= done;
            ce_n_q <= 1'b1;
            oe_n_q <= 1'b1;
            we_n_q <= 1'b1;       // write data still driven through done
        end else if (in_access) begin
            wait_cnt <= wait_cnt - 3'd1;
        end else if (state == done) begin
            state   <= idle;
            drive_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start_data || start_inst) begin
            addr_q  <= sel_req.address[21:2];
            wdata_q <= sel_req.wdata;
            be_n_q  <= sel_req.write ? ~sel_req.be : 4'b0000;
        end
        if (last_cycle && we_n_q) begin
            rdata_q <= sram_rdata;   // read word held for done
        end
    end

    always_comb begin
        sram.addr  = addr_q;
        sram.wdata = wdata_q;
        sram.drive = drive_q;
        sram.be_n  = be_n_q;
        sram.ce_n  = ce_n_q;
        sram.oe_n  = oe_n_q;
        sram.we_n  = we_n_q;
    end

    // stall drops only in the done cycle of the granted port
    always_comb begin
        data_resp.rdata = rdata_q;
        data_resp.stall = data_pending & ~((state == done) & gnt_data);
        inst_resp.rdata = rdata_q;
        inst_resp.stall = inst_pending & ~((state == done) & ~gnt_data);
    end

endmodule

// File: src/thinpad_mem.sv
`timescale 1ns/1ps

module thinpad_mem #(
    parameter int unsigned sram_wait = 2
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  thinpad_pkg::bus_req_t   inst_req,
    output thinpad_pkg::bus_resp_t  inst_resp,
    input  thinpad_pkg::bus_req_t   data_req,
    output thinpad_pkg::bus_resp_t  data_resp,
    output thinpad_pkg::sram_pins_t sram,
    input  logic [31:0]             sram_rdata,
    output logic                    timer_irq
);
    import thinpad_pkg::*;

    bus_req_t  rom_req;
    bus_resp_t rom_resp;
    bus_req_t  ram_inst_req;
    bus_resp_t ram_inst_resp;
    bus_req_t  ram_data_req;
    bus_resp_t ram_data_resp;
    bus_req_t  timer_req;
    bus_resp_t timer_resp;

    // instruction side: boot rom or base_ram
    instruction_bus instruction_bus_instance (
        .cpu_req  (inst_req),
        .cpu_resp (inst_resp),
        .rom_req  (rom_req),
        .rom_resp (rom_resp),
        .ram_req  (ram_inst_req),
        .ram_resp (ram_inst_resp)
    );

    data_bus data_bus_instance (
        .cpu_req    (data_req),
        .cpu_resp   (data_resp),
        .ram_req    (ram_data_req),
        .ram_resp   (ram_data_resp),
        .timer_req  (timer_req),
        .timer_resp (timer_resp)
    );

    // peripherals
    bootrom bootrom_instance (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (rom_req),
        .resp  (rom_resp)
    );

    timer timer_instance (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (timer_req),
        .resp  (timer_resp),
        .irq   (timer_irq)
    );

    sram_controller #(
        .sram_wait (sram_wait)
    ) sram_controller_instance (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_req   (ram_inst_req),
        .inst_resp  (ram_inst_resp),
        .data_req   (ram_data_req),
        .data_resp  (ram_data_resp),
        .sram       (sram),
        .sram_rdata (sram_rdata)
    );

endmodule

// File: bench/sram_model.sv
`timescale 1ns/1ps

module sram_model (
    input  thinpad_pkg::sram_pins_t pins,
    output logic [31:0]             rdata
);
    logic [31:0] mem [1 << 20];   // 4 MiB, word addressed

    // write lands on the rising we_n, data is still driven then
    always @(posedge pins.we_n) begin
        if (pins.drive) begin
            for (int i = 0; i < 4; i++) begin
                if (!pins.be_n[i]) begin
                    mem[pins.addr][8*i +: 8] <= pins.wdata[8*i +: 8];
                end
            end
        end
    end

    // asynchronous read while selected and output enabled
    assign rdata = (!pins.ce_n && !pins.oe_n) ? mem[pins.addr] : 32'h0;

endmodule

// File: bench/tb_thinpad_mem.sv
`timescale 1ns/1ps

module tb_thinpad_mem;
    import thinpad_pkg::*;

    logic        clk;
    logic        rst_n;
    bus_req_t    inst_req;
    bus_resp_t   inst_resp;
    bus_req_t    data_req;
    bus_resp_t   data_resp;
    sram_pins_t  sram;
    logic [31:0] sram_rdata;
    logic        timer_irq;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] rom_ref [bootrom_words];
    logic [31:0] ref_mem [logic [31:0]];   // word written per byte address

    thinpad_mem #(.sram_wait(2)) dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_req   (inst_req),
        .inst_resp  (inst_resp),
        .data_req   (data_req),
        .data_resp  (data_resp),
        .sram       (sram),
        .sram_rdata (sram_rdata),
        .timer_irq  (timer_irq)
    );

    sram_model sram0 (.pins(sram), .rdata(sram_rdata));

    always #10 clk = ~clk;

    // irq holds once raised while compare stays fixed
    assert property (@(posedge clk) disable iff (!rst_n) timer_irq |=> timer_irq)
        else begin
            $display("timer_irq dropped after it had been raised");
            errors++;
        end

    // a port with no strobe must never see stall
    assert property (@(posedge clk) disable iff (!rst_n)
        !(data_req.read || data_req.write) |-> !data_resp.stall)
        else begin
            $display("data port stalled without a request");
            errors++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        !(inst_req.read || inst_req.write) |-> !inst_resp.stall)
        else begin
            $display("instruction port stalled without a request");
            errors++;
        end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            $display("[ERROR] %s expected %h actual %h", name, exp, got);
            errors++;
        end
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  be);
        logic [31:0] m;
        m = old_w;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                m[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return m;
    endfunction

    // one access on either port held until stall drops
    task automatic bus_access(input bit inst, input bit wr, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] be,
                              output logic [31:0] rdata, output int waited);
        bus_req_t r;
        int       n;
        r.read    = !wr;
        r.write   = wr;
        r.address = addr;
        r.wdata   = wdata;
        r.be      = be;
        @(posedge clk);
        if (inst) inst_req <= r;
        else data_req <= r;
        n = 0;
        @(negedge clk);
        while ((inst ? inst_resp.stall : data_resp.stall) && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (n >= 100) begin
            $display("timeout, stall never dropped for address %h", addr);
            errors++;
        end
        rdata  = inst ? inst_resp.rdata : data_resp.rdata;
        waited = n;
        @(posedge clk);
        r.read  = 1'b0;
        r.write = 1'b0;
        if (inst) inst_req <= r;
        else data_req <= r;
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] addr_list [6];
        logic [31:0] w;
        logic [31:0] rd;
        logic [31:0] rd_i;
        logic [31:0] c;
        logic [31:0] prev;
        logic [31:0] cmp;
        logic [3:0]  be;
        int          n;
        int          n_i;
        int          k;
        bit          seen;

        clk      = 1'b0;
        rst_n    = 1'b0;
        inst_req = '0;
        data_req = '0;
        void'($urandom(32'h2de9f49c));
        $readmemh("src/bootrom.mem", rom_ref);
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        check("idle inst stall", 0, 32'(inst_resp.stall));
        check("idle data stall", 0, 32'(data_resp.stall));
        check("idle timer_irq", 0, 32'(timer_irq));
        check("idle sram ce_n", 1, 32'(sram.ce_n));
        check("idle sram we_n", 1, 32'(sram.we_n));
        check("idle sram drive", 0, 32'(sram.drive));

        for (int i = 0; i < 6; i++) begin
            addr         = ram_base | ($urandom & 32'h003f_fffc);
            addr_list[i] = addr;
            w            = $urandom;
            bus_access(0, 1, addr, w, 4'hf, rd, n);
            ref_mem[addr] = w;
            w  = $urandom;
            be = 4'($urandom);
            bus_access(0, 1, addr, w, be, rd, n);   // partial write over known word
            ref_mem[addr] = merge_bytes(ref_mem[addr], w, be);
            bus_access(0, 0, addr, 32'h0, 4'hf, rd, n);
            check("ram masked write readback", ref_mem[addr], rd);
        end

        // fetch the written words back through the instruction port
        for (int i = 0; i < 6; i++) begin
            bus_access(1, 0, addr_list[i], 32'h0, 4'hf, rd, n);
            check("fetch from ram", ref_mem[addr_list[i]], rd);
        end

        for (int i = 0; i < bootrom_words; i++) begin
            bus_access(1, 0, bootrom_base + 32'(4 * i), 32'h0, 4'hf, rd, n);
            check("fetch from boot rom", rom_ref[i], rd);
        end

        // data wins when both ports ask at once
        fork
            bus_access(0, 0, addr_list[1], 32'h0, 4'hf, rd, n);
            bus_access(1, 0, addr_list[4], 32'h0, 4'hf, rd_i, n_i);
        join
        check("concurrent data read", ref_mem[addr_list[1]], rd);
        check("concurrent fetch", ref_mem[addr_list[4]], rd_i);
        check("data done before inst", 1, 32'(n <= n_i));

        bus_access(0, 0, timer_base, 32'h0, 4'hf, c, n);
        cmp = c + 32'd40;
        bus_access(0, 1, timer_base + 32'd4, cmp, 4'hf, rd, n);
        @(posedge clk);
        data_req.read    <= 1'b1;   // held read of count
        data_req.address <= timer_base;
        prev = c;
        seen = 1'b0;
        k    = 0;
        while (!seen && k < 100) begin
            @(negedge clk);
            c = data_resp.rdata;
            check("timer count rising", 1, 32'(c > prev));
            prev = c;
            if (timer_irq) begin
                seen = 1'b1;
                check("irq once count passed compare", 1, 32'(c > cmp));
            end else begin
                check("irq low before compare", 1, 32'(c <= cmp));
            end
            k++;
        end
        if (!seen) begin
            $display("timeout, timer_irq never rose after compare was written");
            errors++;
        end
        @(posedge clk);
        data_req.read <= 1'b0;

        @(posedge clk);
        data_req.read    <= 1'b1;
        data_req.address <= 32'h4000_0010;   // nothing mapped here
        @(negedge clk);
        check("unmapped stall", 0, 32'(data_resp.stall));
        check("unmapped rdata", 0, data_resp.rdata);
        @(posedge clk);
        data_req.read <= 1'b0;
        repeat (3) @(posedge clk);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: src/bootrom.mem
// one 32-bit word per line, word 0 sits at 1fc0_0000
3c08bfd0
8d090000
3c0a8000
ad490000
8d4b0000
256b0001
ad4b0004
3c0c0000
258c0010
010c6821
ad0d0004
1000ffff
00000000
00000000
deadbeef
1fc0c0de

// File: vlog.f
src/thinpad_pkg.sv
src/instruction_bus.sv
src/data_bus.sv
src/bootrom.sv
src/timer.sv
src/sram_controller.sv
src/thinpad_mem.sv
bench/sram_model.sv
bench/tb_thinpad_mem.sv

// File: Makefile
TOP := tb_thinpad_mem

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
